/* lpif_pkg.sv */
// shared types and width helpers for the LPIF-to-AIB adapter
// modules import this package inside their bodies and use
// scoped names in their port headers

package lpif_pkg;

  ////////////////////////////////////////////////////////////
  // link control states
  ////////////////////////////////////////////////////////////

  // bring-up order, with the sticky error at the end
  typedef enum logic [2:0] {
    CTL_IDLE       = 3'd0,
    CTL_PHY_INIT   = 3'd1,
    CTL_CFG        = 3'd2,
    CTL_CALIB      = 3'd3,
    CTL_WAIT_ALIGN = 3'd4,
    CTL_LINK_UP    = 3'd5,
    CTL_PHY_ERR    = 3'd6
  } ctl_state_e;

  ////////////////////////////////////////////////////////////
  // protocol ids on the AIB side
  ////////////////////////////////////////////////////////////

  // code 3 is unassigned and decodes like the cache protocol
  typedef enum logic [1:0] {
    PROTID_CACHE   = 2'd0,
    PROTID_IO      = 2'd1,
    PROTID_ARB_MUX = 2'd2
  } protid_e;

  ////////////////////////////////////////////////////////////
  // width helpers, argument is the data width in bytes
  ////////////////////////////////////////////////////////////

  // one valid bit per 64 bytes of beat
  function automatic int lpif_valid_width(input int data_bytes);
    int w;
    w = 1;
    if (data_bytes == 128) begin
      w = 2;
    end
    return w;
  endfunction

  // 16-bit crc per valid group
  function automatic int lpif_crc_width(input int data_bytes);
    int w;
    w = 16;
    if (data_bytes == 128) begin
      w = 32;
    end
    return w;
  endfunction

endpackage

/* lpif_stream_decode.sv */
// decode stage of the adapter
// maps link-layer stream ids to protocol ids and back, and folds
// the per-lane AIB status into the calibration and error flags

`timescale 1ns/1ps

module lpif_stream_decode #(
  parameter int       AIB_LANES           = 4,
  parameter bit [7:0] MEM_CACHE_STREAM_ID = 8'h1,
  parameter bit [7:0] IO_STREAM_ID        = 8'h2,
  parameter bit [7:0] ARB_MUX_STREAM_ID   = 8'h3
) (
  input  logic [7:0]           lp_stream,
  input  lpif_pkg::protid_e    ustrm_protid,
  input  logic [AIB_LANES-1:0] ms_tx_transfer_en,
  input  logic [AIB_LANES-1:0] sl_tx_transfer_en,
  input  logic [AIB_LANES-1:0] wa_error,
  input  logic                 lp_linkerror,
  output lpif_pkg::protid_e    dstrm_protid_nxt,
  output logic [7:0]           pl_stream_nxt,
  output logic                 tx_en_all,
  output logic                 phy_err
);

  import lpif_pkg::*;

  ////////////////////////////////////////////////////////////
  // downstream, stream id to protocol id
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (lp_stream)
      MEM_CACHE_STREAM_ID: dstrm_protid_nxt = PROTID_CACHE;
      IO_STREAM_ID:        dstrm_protid_nxt = PROTID_IO;
      ARB_MUX_STREAM_ID:   dstrm_protid_nxt = PROTID_ARB_MUX;
      // unknown streams ride on the cache protocol
      default:             dstrm_protid_nxt = PROTID_CACHE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // upstream, protocol id back to stream id
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (ustrm_protid)
      PROTID_CACHE:   pl_stream_nxt = MEM_CACHE_STREAM_ID;
      PROTID_IO:      pl_stream_nxt = IO_STREAM_ID;
      PROTID_ARB_MUX: pl_stream_nxt = ARB_MUX_STREAM_ID;
      default:        pl_stream_nxt = MEM_CACHE_STREAM_ID;
    endcase
  end

  // every lane of both sides must have its transmitter enabled
  assign tx_en_all = &{ms_tx_transfer_en, sl_tx_transfer_en};

  // lost calibration, word-align error, or link layer error
  assign phy_err = ~tx_en_all | (|wa_error) | lp_linkerror;

endmodule

/* lpif_link_ctl.sv */
// execute stage of the adapter
// link bring-up FSM: phy init, adapter config, calibration,
// alignment wait, link up; a phy error is held until reset

`timescale 1ns/1ps

module lpif_link_ctl #(
  parameter int AIB_LANES = 4
) (
  input  logic                 com_clk,
  input  logic                 rst_n,
  input  logic                 i_conf_done,
  input  logic                 tx_en_all,
  input  logic                 align_done,
  input  logic                 phy_err,
  input  logic                 lsm_state_active,
  input  logic                 lp_irdy,
  output logic                 ns_mac_rdy,
  output logic [AIB_LANES-1:0] ns_adapter_rstn,
  output logic                 tx_online,
  output logic                 rx_online,
  output logic                 link_up,
  output logic                 pl_trdy,
  output logic                 beat_accept,
  output logic                 ctl_phy_err
);

  import lpif_pkg::*;

  ctl_state_e           state;
  ctl_state_e           state_nxt;
  logic                 mac_rdy_nxt;
  logic [AIB_LANES-1:0] adapter_rstn_nxt;
  logic                 online_nxt;

  ////////////////////////////////////////////////////////////
  // next state and bring-up levels
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt        = state;
    mac_rdy_nxt      = ns_mac_rdy;
    adapter_rstn_nxt = ns_adapter_rstn;
    // both directions come online together
    online_nxt       = tx_online;
    case (state)
      CTL_IDLE: begin
        state_nxt = CTL_PHY_INIT;
      end
      CTL_PHY_INIT: begin
        if (i_conf_done) begin
          mac_rdy_nxt = 1'b1;
          state_nxt   = CTL_CFG;
        end
      end
      CTL_CFG: begin
        // release all lane adapters at once
        adapter_rstn_nxt = {AIB_LANES{1'b1}};
        state_nxt        = CTL_CALIB;
      end
      CTL_CALIB: begin
        // a partial set of enables keeps us here
        if (tx_en_all) begin
          online_nxt = 1'b1;
          state_nxt  = CTL_WAIT_ALIGN;
        end
      end
      CTL_WAIT_ALIGN: begin
        if (align_done) begin
          state_nxt = CTL_LINK_UP;
        end
      end
      CTL_LINK_UP: begin
        if (phy_err) begin
          state_nxt = CTL_PHY_ERR;
        end
      end
      CTL_PHY_ERR: begin
        // sticky until rst_n
        state_nxt = CTL_PHY_ERR;
      end
      default: begin
        state_nxt = CTL_IDLE;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // state and output registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge com_clk or negedge rst_n) begin
    if (!rst_n) begin
      state           <= CTL_IDLE;
      ns_mac_rdy      <= 1'b0;
      ns_adapter_rstn <= '0;
      tx_online       <= 1'b0;
      rx_online       <= 1'b0;
    end else begin
      state           <= state_nxt;
      ns_mac_rdy      <= mac_rdy_nxt;
      ns_adapter_rstn <= adapter_rstn_nxt;
      tx_online       <= online_nxt;
      rx_online       <= online_nxt;
    end
  end

  // status decoded from the state register
  assign link_up     = (state == CTL_LINK_UP);
  assign ctl_phy_err = (state == CTL_PHY_ERR);

  // link layer may push only while the link is up and the lsm is active
  assign pl_trdy     = link_up & lsm_state_active;
  assign beat_accept = lp_irdy & pl_trdy;

endmodule

/* lpif_beat_regs.sv */
// result stage of the adapter
// single register stage for downstream beats, upstream beats
// and the link state sideband; everything lands one cycle later

`timescale 1ns/1ps

module lpif_beat_regs #(
  parameter int LPIF_DATA_WIDTH = 8
) (
  input  logic                                                com_clk,
  input  logic                                                rst_n,
  input  logic [LPIF_DATA_WIDTH*8-1:0]                        lp_data,
  input  logic [lpif_pkg::lpif_valid_width(LPIF_DATA_WIDTH)-1:0] lp_valid,
  input  logic [lpif_pkg::lpif_crc_width(LPIF_DATA_WIDTH)-1:0]   lp_crc,
  input  logic [lpif_pkg::lpif_valid_width(LPIF_DATA_WIDTH)-1:0] lp_crc_valid,
  input  lpif_pkg::protid_e                                   dstrm_protid_nxt,
  input  logic                                                beat_accept,
  input  logic [LPIF_DATA_WIDTH*8-1:0]                        ustrm_data,
  input  logic [lpif_pkg::lpif_valid_width(LPIF_DATA_WIDTH)-1:0] ustrm_dvalid,
  input  logic [lpif_pkg::lpif_crc_width(LPIF_DATA_WIDTH)-1:0]   ustrm_crc,
  input  logic [lpif_pkg::lpif_valid_width(LPIF_DATA_WIDTH)-1:0] ustrm_crc_valid,
  input  logic [7:0]                                          pl_stream_nxt,
  input  logic [3:0]                                          lsm_dstrm_state,
  input  logic [2:0]                                          lsm_lnk_cfg,
  input  logic [2:0]                                          lsm_speedmode,
  output logic [LPIF_DATA_WIDTH*8-1:0]                        dstrm_data,
  output logic [lpif_pkg::lpif_valid_width(LPIF_DATA_WIDTH)-1:0] dstrm_dvalid,
  output logic [lpif_pkg::lpif_crc_width(LPIF_DATA_WIDTH)-1:0]   dstrm_crc,
  output logic [lpif_pkg::lpif_valid_width(LPIF_DATA_WIDTH)-1:0] dstrm_crc_valid,
  output lpif_pkg::protid_e                                   dstrm_protid,
  output logic                                                dstrm_valid,
  output logic [LPIF_DATA_WIDTH*8-1:0]                        pl_data,
  output logic [lpif_pkg::lpif_valid_width(LPIF_DATA_WIDTH)-1:0] pl_valid,
  output logic [lpif_pkg::lpif_crc_width(LPIF_DATA_WIDTH)-1:0]   pl_crc,
  output logic [lpif_pkg::lpif_valid_width(LPIF_DATA_WIDTH)-1:0] pl_crc_valid,
  output logic [7:0]                                          pl_stream,
  output logic [3:0]                                          dstrm_state,
  output logic [2:0]                                          pl_lnk_cfg,
  output logic [2:0]                                          pl_speedmode
);

  import lpif_pkg::*;

  ////////////////////////////////////////////////////////////
  // downstream toward AIB
  ////////////////////////////////////////////////////////////

  // payload follows the inputs every cycle, only dstrm_valid qualifies it
  always_ff @(posedge com_clk or negedge rst_n) begin
    if (!rst_n) begin
      dstrm_data      <= '0;
      dstrm_dvalid    <= '0;
      dstrm_crc       <= '0;
      dstrm_crc_valid <= '0;
      dstrm_protid    <= PROTID_CACHE;
      dstrm_valid     <= 1'b0;
    end else begin
      dstrm_data      <= lp_data;
      dstrm_dvalid    <= lp_valid;
      dstrm_crc       <= lp_crc;
      dstrm_crc_valid <= lp_crc_valid;
      dstrm_protid    <= dstrm_protid_nxt;
      dstrm_valid     <= beat_accept;
    end
  end

  ////////////////////////////////////////////////////////////
  // upstream toward link layer, plus lsm sideband
  ////////////////////////////////////////////////////////////

  always_ff @(posedge com_clk or negedge rst_n) begin
    if (!rst_n) begin
      pl_data      <= '0;
      pl_valid     <= '0;
      pl_crc       <= '0;
      pl_crc_valid <= '0;
      pl_stream    <= 8'h0;
      dstrm_state  <= 4'h0;
      pl_lnk_cfg   <= 3'h0;
      pl_speedmode <= 3'h0;
    end else begin
      pl_data      <= ustrm_data;
      pl_valid     <= ustrm_dvalid;
      pl_crc       <= ustrm_crc;
      pl_crc_valid <= ustrm_crc_valid;
      pl_stream    <= pl_stream_nxt;
      // sideband is registered in every control state
      dstrm_state  <= lsm_dstrm_state;
      pl_lnk_cfg   <= lsm_lnk_cfg;
      pl_speedmode <= lsm_speedmode;
    end
  end

endmodule

/* lpif_adapter_top.sv */
// top level of the LPIF-to-AIB adapter control block
// sets the lane count, data width and stream ids, and connects
// the decode, control and result stages; all on com_clk

`timescale 1ns/1ps

module lpif_adapter_top #(
  parameter int       AIB_LANES           = 4,
  parameter int       LPIF_DATA_WIDTH     = 8,
  parameter bit [7:0] MEM_CACHE_STREAM_ID = 8'h1,
  parameter bit [7:0] IO_STREAM_ID        = 8'h2,
  parameter bit [7:0] ARB_MUX_STREAM_ID   = 8'h3
) (
  input  logic                                                com_clk,
  input  logic                                                rst_n,
  // link layer downstream
  input  logic                                                lp_irdy,
  input  logic [7:0]                                          lp_stream,
  input  logic [LPIF_DATA_WIDTH*8-1:0]                        lp_data,
  input  logic [lpif_pkg::lpif_valid_width(LPIF_DATA_WIDTH)-1:0] lp_valid,
  input  logic [lpif_pkg::lpif_crc_width(LPIF_DATA_WIDTH)-1:0]   lp_crc,
  input  logic [lpif_pkg::lpif_valid_width(LPIF_DATA_WIDTH)-1:0] lp_crc_valid,
  input  logic                                                lp_linkerror,
  output logic                                                pl_trdy,
  // AIB side, downstream
  output logic [LPIF_DATA_WIDTH*8-1:0]                        dstrm_data,
  output logic [lpif_pkg::lpif_valid_width(LPIF_DATA_WIDTH)-1:0] dstrm_dvalid,
  output logic [lpif_pkg::lpif_crc_width(LPIF_DATA_WIDTH)-1:0]   dstrm_crc,
  output logic [lpif_pkg::lpif_valid_width(LPIF_DATA_WIDTH)-1:0] dstrm_crc_valid,
  output lpif_pkg::protid_e                                   dstrm_protid,
  output logic                                                dstrm_valid,
  output logic [3:0]                                          dstrm_state,
  // AIB side, upstream
  input  lpif_pkg::protid_e                                   ustrm_protid,
  input  logic [LPIF_DATA_WIDTH*8-1:0]                        ustrm_data,
  input  logic [lpif_pkg::lpif_valid_width(LPIF_DATA_WIDTH)-1:0] ustrm_dvalid,
  input  logic [lpif_pkg::lpif_crc_width(LPIF_DATA_WIDTH)-1:0]   ustrm_crc,
  input  logic [lpif_pkg::lpif_valid_width(LPIF_DATA_WIDTH)-1:0] ustrm_crc_valid,
  // link layer upstream
  output logic [LPIF_DATA_WIDTH*8-1:0]                        pl_data,
  output logic [lpif_pkg::lpif_valid_width(LPIF_DATA_WIDTH)-1:0] pl_valid,
  output logic [lpif_pkg::lpif_crc_width(LPIF_DATA_WIDTH)-1:0]   pl_crc,
  output logic [lpif_pkg::lpif_valid_width(LPIF_DATA_WIDTH)-1:0] pl_crc_valid,
  output logic [7:0]                                          pl_stream,
  output logic [2:0]                                          pl_lnk_cfg,
  output logic [2:0]                                          pl_speedmode,
  // AIB bring-up
  input  logic                                                i_conf_done,
  input  logic [AIB_LANES-1:0]                                ms_tx_transfer_en,
  input  logic [AIB_LANES-1:0]                                sl_tx_transfer_en,
  input  logic [AIB_LANES-1:0]                                wa_error,
  input  logic                                                align_done,
  output logic                                                ns_mac_rdy,
  output logic [AIB_LANES-1:0]                                ns_adapter_rstn,
  output logic                                                tx_online,
  output logic                                                rx_online,
  // link state machine
  input  logic [3:0]                                          lsm_dstrm_state,
  input  logic [2:0]                                          lsm_lnk_cfg,
  input  logic [2:0]                                          lsm_speedmode,
  input  logic                                                lsm_state_active,
  output logic                                                ctl_link_up,
  output logic                                                ctl_phy_err
);

  import lpif_pkg::*;

  protid_e    dstrm_protid_nxt;
  logic [7:0] pl_stream_nxt;
  logic       tx_en_all;
  logic       phy_err;
  logic       beat_accept;

  ////////////////////////////////////////////////////////////
  // decode, execute, result
  ////////////////////////////////////////////////////////////

  lpif_stream_decode #(
    .AIB_LANES           (AIB_LANES),
    .MEM_CACHE_STREAM_ID (MEM_CACHE_STREAM_ID),
    .IO_STREAM_ID        (IO_STREAM_ID),
    .ARB_MUX_STREAM_ID   (ARB_MUX_STREAM_ID)
  ) u_decode (
    .lp_stream         (lp_stream),
    .ustrm_protid      (ustrm_protid),
    .ms_tx_transfer_en (ms_tx_transfer_en),
    .sl_tx_transfer_en (sl_tx_transfer_en),
    .wa_error          (wa_error),
    .lp_linkerror      (lp_linkerror),
    .dstrm_protid_nxt  (dstrm_protid_nxt),
    .pl_stream_nxt     (pl_stream_nxt),
    .tx_en_all         (tx_en_all),
    .phy_err           (phy_err)
  );

  lpif_link_ctl #(
    .AIB_LANES (AIB_LANES)
  ) u_link_ctl (
    .com_clk          (com_clk),
    .rst_n            (rst_n),
    .i_conf_done      (i_conf_done),
    .tx_en_all        (tx_en_all),
    .align_done       (align_done),
    .phy_err          (phy_err),
    .lsm_state_active (lsm_state_active),
    .lp_irdy          (lp_irdy),
    .ns_mac_rdy       (ns_mac_rdy),
    .ns_adapter_rstn  (ns_adapter_rstn),
    .tx_online        (tx_online),
    .rx_online        (rx_online),
    .link_up          (ctl_link_up),
    .pl_trdy          (pl_trdy),
    .beat_accept      (beat_accept),
    .ctl_phy_err      (ctl_phy_err)
  );

  lpif_beat_regs #(
    .LPIF_DATA_WIDTH (LPIF_DATA_WIDTH)
  ) u_beat_regs (
    .com_clk          (com_clk),
    .rst_n            (rst_n),
    .lp_data          (lp_data),
    .lp_valid         (lp_valid),
    .lp_crc           (lp_crc),
    .lp_crc_valid     (lp_crc_valid),
    .dstrm_protid_nxt (dstrm_protid_nxt),
    .beat_accept      (beat_accept),
    .ustrm_data       (ustrm_data),
    .ustrm_dvalid     (ustrm_dvalid),
    .ustrm_crc        (ustrm_crc),
    .ustrm_crc_valid  (ustrm_crc_valid),
    .pl_stream_nxt    (pl_stream_nxt),
    .lsm_dstrm_state  (lsm_dstrm_state),
    .lsm_lnk_cfg      (lsm_lnk_cfg),
    .lsm_speedmode    (lsm_speedmode),
    .dstrm_data       (dstrm_data),
    .dstrm_dvalid     (dstrm_dvalid),
    .dstrm_crc        (dstrm_crc),
    .dstrm_crc_valid  (dstrm_crc_valid),
    .dstrm_protid     (dstrm_protid),
    .dstrm_valid      (dstrm_valid),
    .pl_data          (pl_data),
    .pl_valid         (pl_valid),
    .pl_crc           (pl_crc),
    .pl_crc_valid     (pl_crc_valid),
    .pl_stream        (pl_stream),
    .dstrm_state      (dstrm_state),
    .pl_lnk_cfg       (pl_lnk_cfg),
    .pl_speedmode     (pl_speedmode)
  );

endmodule

/* lpif_checker.sv */
// testbench monitor for the adapter
// models the bring-up FSM from the input history and checks every
// DUT output at the falling edge of com_clk, counting mismatches

`timescale 1ns/1ps

module lpif_checker #(
  parameter int AIB_LANES       = 4,
  parameter int LPIF_DATA_WIDTH = 8
) (
  input  logic                         com_clk, rst_n,
  input  logic                         i_conf_done, align_done, lp_linkerror,
  input  logic                         lsm_state_active, lp_irdy,
  input  logic [AIB_LANES-1:0]         ms_tx_transfer_en, sl_tx_transfer_en, wa_error,
  input  logic [7:0]                   lp_stream,
  input  lpif_pkg::protid_e            ustrm_protid,
  input  logic [LPIF_DATA_WIDTH*8-1:0] lp_data, ustrm_data,
  input  logic [lpif_pkg::lpif_valid_width(LPIF_DATA_WIDTH)-1:0] lp_valid, lp_crc_valid,
  input  logic [lpif_pkg::lpif_valid_width(LPIF_DATA_WIDTH)-1:0] ustrm_dvalid,
  input  logic [lpif_pkg::lpif_valid_width(LPIF_DATA_WIDTH)-1:0] ustrm_crc_valid,
  input  logic [lpif_pkg::lpif_crc_width(LPIF_DATA_WIDTH)-1:0]   lp_crc, ustrm_crc,
  input  logic [3:0]                   lsm_dstrm_state, dstrm_state,
  input  logic [2:0]                   lsm_lnk_cfg, lsm_speedmode, pl_lnk_cfg, pl_speedmode,
  // DUT outputs
  input  logic                         ns_mac_rdy, tx_online, rx_online,
  input  logic                         ctl_link_up, ctl_phy_err, pl_trdy, dstrm_valid,
  input  logic [AIB_LANES-1:0]         ns_adapter_rstn,
  input  logic [LPIF_DATA_WIDTH*8-1:0] dstrm_data, pl_data,
  input  logic [lpif_pkg::lpif_valid_width(LPIF_DATA_WIDTH)-1:0] dstrm_dvalid, pl_valid,
  input  logic [lpif_pkg::lpif_valid_width(LPIF_DATA_WIDTH)-1:0] dstrm_crc_valid,
  input  logic [lpif_pkg::lpif_valid_width(LPIF_DATA_WIDTH)-1:0] pl_crc_valid,
  input  logic [lpif_pkg::lpif_crc_width(LPIF_DATA_WIDTH)-1:0]   dstrm_crc, pl_crc,
  input  lpif_pkg::protid_e            dstrm_protid,
  input  logic [7:0]                   pl_stream,
  output int                           err_count
);

  import lpif_pkg::*;

  localparam int VW = lpif_valid_width(LPIF_DATA_WIDTH);
  localparam int CW = lpif_crc_width(LPIF_DATA_WIDTH);

  ctl_state_e                   m_state;
  logic                         m_mac_rdy, m_online, live, exp_valid;
  logic [AIB_LANES-1:0]         m_rstn;
  // inputs as they stood at the last rising edge
  logic                         p_rst_n = 1'b0;
  logic                         p_conf, p_align, p_lerr, p_act, p_irdy;
  logic [AIB_LANES-1:0]         p_ms, p_sl, p_wa;
  logic [7:0]                   p_stream;
  logic [1:0]                   p_protid;
  logic [LPIF_DATA_WIDTH*8-1:0] p_lp_data, p_us_data;
  logic [VW-1:0]                p_lp_valid, p_lp_crc_valid, p_us_dvalid, p_us_crc_valid;
  logic [CW-1:0]                p_lp_crc, p_us_crc;
  logic [3:0]                   p_lsm_state;
  logic [2:0]                   p_lnk_cfg, p_speedmode;

  initial err_count = 0;

  // stream ids 1, 2, 3 carry cache, io, arb-mux; others ride as cache
  function automatic logic [1:0] expected_protid(input logic [7:0] stream);
    case (stream)
      8'd1:    return 2'd0;
      8'd2:    return 2'd1;
      8'd3:    return 2'd2;
      default: return 2'd0;
    endcase
  endfunction

  function automatic logic [7:0] expected_stream(input logic [1:0] protid);
    case (protid)
      2'd1:    return 8'd2;
      2'd2:    return 8'd3;
      default: return 8'd1;
    endcase
  endfunction

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] want);
    if (got !== want) begin
      $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, want);
      err_count++;
    end
  endtask

  // one rising edge of the bring-up sequence
  task automatic step_model();
    logic lanes_on;
    lanes_on = (p_ms == {AIB_LANES{1'b1}}) && (p_sl == {AIB_LANES{1'b1}});
    case (m_state)
      CTL_IDLE: m_state = CTL_PHY_INIT;
      CTL_PHY_INIT: begin
        if (p_conf) begin
          m_mac_rdy = 1'b1;
          m_state   = CTL_CFG;
        end
      end
      CTL_CFG: begin
        m_rstn  = '1;
        m_state = CTL_CALIB;
      end
      CTL_CALIB: begin
        if (lanes_on) begin
          m_online = 1'b1;
          m_state  = CTL_WAIT_ALIGN;
        end
      end
      CTL_WAIT_ALIGN: begin
        if (p_align) m_state = CTL_LINK_UP;
      end
      CTL_LINK_UP: begin
        if (!lanes_on || (p_wa != '0) || p_lerr) m_state = CTL_PHY_ERR;
      end
      default: ;
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // compare at the falling edge, outputs and inputs both settled
  ////////////////////////////////////////////////////////////

  always @(negedge com_clk) begin
    live      = rst_n && p_rst_n;
    exp_valid = live && p_irdy && p_act && (m_state == CTL_LINK_UP);
    if (live) begin
      step_model();
    end else begin
      m_state   = CTL_IDLE;
      m_mac_rdy = 1'b0;
      m_rstn    = '0;
      m_online  = 1'b0;
    end
    compare("ns_mac_rdy", ns_mac_rdy, m_mac_rdy);
    compare("ns_adapter_rstn", ns_adapter_rstn, m_rstn);
    compare("tx_online", tx_online, m_online);
    compare("rx_online", rx_online, m_online);
    compare("ctl_link_up", ctl_link_up, m_state == CTL_LINK_UP);
    compare("ctl_phy_err", ctl_phy_err, m_state == CTL_PHY_ERR);
    compare("pl_trdy", pl_trdy, (m_state == CTL_LINK_UP) && lsm_state_active);
    compare("dstrm_valid", dstrm_valid, exp_valid);
    compare("dstrm_data", dstrm_data, live ? p_lp_data : '0);
    compare("dstrm_dvalid", dstrm_dvalid, live ? p_lp_valid : '0);
    compare("dstrm_crc", dstrm_crc, live ? p_lp_crc : '0);
    compare("dstrm_crc_valid", dstrm_crc_valid, live ? p_lp_crc_valid : '0);
    compare("dstrm_protid", dstrm_protid, live ? expected_protid(p_stream) : 2'd0);
    compare("pl_data", pl_data, live ? p_us_data : '0);
    compare("pl_valid", pl_valid, live ? p_us_dvalid : '0);
    compare("pl_crc", pl_crc, live ? p_us_crc : '0);
    compare("pl_crc_valid", pl_crc_valid, live ? p_us_crc_valid : '0);
    compare("pl_stream", pl_stream, live ? expected_stream(p_protid) : 8'd0);
    compare("dstrm_state", dstrm_state, live ? p_lsm_state : 4'd0);
    compare("pl_lnk_cfg", pl_lnk_cfg, live ? p_lnk_cfg : 3'd0);
    compare("pl_speedmode", pl_speedmode, live ? p_speedmode : 3'd0);
    // these feed the next rising edge
    p_rst_n        = rst_n;
    p_conf         = i_conf_done;
    p_align        = align_done;
    p_lerr         = lp_linkerror;
    p_act          = lsm_state_active;
    p_irdy         = lp_irdy;
    p_ms           = ms_tx_transfer_en;
    p_sl           = sl_tx_transfer_en;
    p_wa           = wa_error;
    p_stream       = lp_stream;
    p_protid       = ustrm_protid;
    p_lp_data      = lp_data;
    p_lp_valid     = lp_valid;
    p_lp_crc       = lp_crc;
    p_lp_crc_valid = lp_crc_valid;
    p_us_data      = ustrm_data;
    p_us_dvalid    = ustrm_dvalid;
    p_us_crc       = ustrm_crc;
    p_us_crc_valid = ustrm_crc_valid;
    p_lsm_state    = lsm_dstrm_state;
    p_lnk_cfg      = lsm_lnk_cfg;
    p_speedmode    = lsm_speedmode;
  end

endmodule

/* tb_lpif_adapter.sv */
// testbench for the LPIF-to-AIB adapter control block
// applies a table of link, lane and beat stimulus row by row,
// lpif_checker compares every DUT output and counts errors

`timescale 1ns/1ps

module tb_lpif_adapter;

  import lpif_pkg::*;

  logic        com_clk = 1'b0;
  logic        rst_n, lp_irdy, lp_linkerror, i_conf_done, align_done;
  logic        lsm_state_active, pl_trdy, dstrm_valid, ns_mac_rdy;
  logic        tx_online, rx_online, ctl_link_up, ctl_phy_err;
  logic [0:0]  lp_valid, lp_crc_valid, ustrm_dvalid, ustrm_crc_valid;
  logic [0:0]  dstrm_dvalid, dstrm_crc_valid, pl_valid, pl_crc_valid;
  logic [3:0]  ms_tx_transfer_en, sl_tx_transfer_en, wa_error, ns_adapter_rstn;
  logic [3:0]  lsm_dstrm_state, dstrm_state;
  logic [2:0]  lsm_lnk_cfg, lsm_speedmode, pl_lnk_cfg, pl_speedmode;
  logic [7:0]  lp_stream, pl_stream;
  logic [15:0] lp_crc, ustrm_crc, dstrm_crc, pl_crc;
  logic [63:0] lp_data, ustrm_data, dstrm_data, pl_data;
  protid_e     ustrm_protid, dstrm_protid;
  int          err_count;
  int          cycle_count = 0;
  // packed row fields from msb down are rst, conf, ms_en, sl_en, align,
  // wa_err, linkerr, active, irdy, stream and protid
  logic [27:0] stim_tab [$];

  lpif_adapter_top DUT (.*);

  lpif_checker u_checker (.*);

  initial begin
    forever #20 com_clk = ~com_clk;
  end

  // run limit from the table length
  always @(posedge com_clk) begin
    cycle_count++;
    if (cycle_count > stim_tab.size() + 20) begin
      $display("timeout: stimulus did not finish within %0d cycles", cycle_count - 1);
      $display("sim failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////

  task automatic add_row(input bit rst, input bit conf, input bit [3:0] ms,
                         input bit [3:0] sl, input bit align, input bit [3:0] wa,
                         input bit lerr, input bit act, input bit irdy,
                         input bit [7:0] strm, input bit [1:0] uprot);
    stim_tab.push_back({rst, conf, ms, sl, align, wa, lerr, act, irdy, strm, uprot});
  endtask

  // idle to link up; early conf and align must be ignored
  task automatic add_bring_up();
    add_row(0, 1, 4'h0, 4'h0, 0, 4'h0, 0, 1, 1, 8'd1, 2'd0);
    add_row(0, 0, 4'h0, 4'h0, 0, 4'h0, 0, 1, 1, 8'd2, 2'd1);
    add_row(0, 1, 4'h0, 4'h0, 0, 4'h0, 0, 1, 1, 8'd3, 2'd2);
    add_row(0, 0, 4'h0, 4'h0, 1, 4'h0, 0, 1, 1, 8'd1, 2'd3);
    // partial enable set holds calibration
    add_row(0, 0, 4'hf, 4'h7, 1, 4'h0, 0, 1, 1, 8'd1, 2'd0);
    add_row(0, 0, 4'hf, 4'hf, 0, 4'h0, 0, 1, 1, 8'd2, 2'd1);
    add_row(0, 0, 4'hf, 4'hf, 0, 4'h0, 0, 1, 1, 8'd3, 2'd2);
    add_row(0, 0, 4'hf, 4'hf, 1, 4'h0, 0, 1, 1, 8'd1, 2'd0);
  endtask

  task automatic build_table();
    add_bring_up();
    // traffic with link up, known and unknown ids, then back-pressure
    add_row(0, 0, 4'hf, 4'hf, 0, 4'h0, 0, 1, 1, 8'd1, 2'd0);
    add_row(0, 0, 4'hf, 4'hf, 0, 4'h0, 0, 1, 1, 8'd2, 2'd1);
    add_row(0, 0, 4'hf, 4'hf, 0, 4'h0, 0, 1, 1, 8'd3, 2'd2);
    add_row(0, 0, 4'hf, 4'hf, 0, 4'h0, 0, 1, 1, 8'd9, 2'd3);
    add_row(0, 0, 4'hf, 4'hf, 0, 4'h0, 0, 0, 1, 8'd2, 2'd1);
    add_row(0, 0, 4'hf, 4'hf, 0, 4'h0, 0, 1, 0, 8'd3, 2'd2);
    add_row(0, 0, 4'hf, 4'hf, 0, 4'h0, 0, 1, 1, 8'hff, 2'd1);
    // word-align error, then the error must stick
    add_row(0, 0, 4'hf, 4'hf, 0, 4'h2, 0, 1, 1, 8'd2, 2'd0);
    add_row(0, 0, 4'hf, 4'hf, 0, 4'h0, 0, 1, 1, 8'd2, 2'd0);
    add_row(0, 0, 4'hf, 4'hf, 1, 4'h0, 0, 1, 1, 8'd3, 2'd2);
    // link layer error after a fresh bring-up
    add_row(1, 0, 4'h0, 4'h0, 0, 4'h0, 0, 1, 1, 8'd1, 2'd0);
    add_bring_up();
    add_row(0, 0, 4'hf, 4'hf, 0, 4'h0, 0, 1, 1, 8'd3, 2'd1);
    add_row(0, 0, 4'hf, 4'hf, 0, 4'h0, 1, 1, 1, 8'd1, 2'd2);
    add_row(0, 0, 4'hf, 4'hf, 0, 4'h0, 0, 1, 1, 8'd2, 2'd0);
    // one lane drops its transfer enable
    add_row(1, 0, 4'h0, 4'h0, 0, 4'h0, 0, 1, 1, 8'd1, 2'd0);
    add_bring_up();
    add_row(0, 0, 4'hf, 4'hf, 0, 4'h0, 0, 1, 1, 8'd2, 2'd2);
    add_row(0, 0, 4'hb, 4'hf, 0, 4'h0, 0, 1, 1, 8'd3, 2'd1);
    add_row(0, 0, 4'hf, 4'hf, 0, 4'h0, 0, 1, 1, 8'd1, 2'd0);
  endtask

  task automatic apply_row(input logic [27:0] row);
    rst_n             = ~row[27];
    i_conf_done       = row[26];
    ms_tx_transfer_en = row[25:22];
    sl_tx_transfer_en = row[21:18];
    align_done        = row[17];
    wa_error          = row[16:13];
    lp_linkerror      = row[12];
    lsm_state_active  = row[11];
    lp_irdy           = row[10];
    lp_stream         = row[9:2];
    ustrm_protid      = protid_e'(row[1:0]);
    // payloads and lsm sideband are random on every row
    lp_data           = {$urandom, $urandom};
    ustrm_data        = {$urandom, $urandom};
    {lp_crc_valid, lp_valid, lp_crc}          = $urandom;
    {ustrm_crc_valid, ustrm_dvalid, ustrm_crc} = $urandom;
    {lsm_dstrm_state, lsm_lnk_cfg, lsm_speedmode} = $urandom;
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(79342));
    build_table();
    apply_row({1'b1, 27'h0});
    repeat (3) @(posedge com_clk);
    #2;
    foreach (stim_tab[i]) begin
      apply_row(stim_tab[i]);
      @(posedge com_clk);
      #2;
    end
    // let the checker see the last row land
    repeat (2) @(posedge com_clk);
    $display("errors: %0d", err_count);
    if (err_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
lpif_pkg.sv
lpif_stream_decode.sv
lpif_link_ctl.sv
lpif_beat_regs.sv
lpif_adapter_top.sv
lpif_checker.sv
tb_lpif_adapter.sv
